/* common/icache_config.svh */
`ifndef ICACHE_CONFIG_SVH
`define ICACHE_CONFIG_SVH

// cache geometry
`define ICACHE_INDEX_BITS    4    // 16 lines
`define ICACHE_OFFSET_BITS   4    // 16 bytes per line

// derived sizes
`define ICACHE_WORD_SEL_BITS (`ICACHE_OFFSET_BITS - 2)
`define ICACHE_TAG_BITS      (32 - `ICACHE_INDEX_BITS - `ICACHE_OFFSET_BITS)
`define ICACHE_LINE_WORDS    (1 << `ICACHE_WORD_SEL_BITS)

`define ICACHE_REQ_CREDITS   2    // credits granted by memory after reset

`endif

/* common/icache_pkg.sv */
`include "icache_config.svh"

package icache_pkg;

    //----------------------------------------------------------------------
    // fetch address layout
    //----------------------------------------------------------------------

    typedef logic [`ICACHE_INDEX_BITS-1:0]    line_index_t;
    typedef logic [`ICACHE_WORD_SEL_BITS-1:0] word_sel_t;
    typedef logic [`ICACHE_TAG_BITS-1:0]      tag_t;

    // msb first: tag, line index, word in line, byte in word
    typedef struct packed {
        tag_t        tag;
        line_index_t index;
        word_sel_t   word_sel;
        logic [1:0]  byte_sel;
    } fetch_fields_t;

    // raw view feeds memory requests, field view feeds the lookup
    typedef union packed {
        logic [31:0]   raw;
        fetch_fields_t f;
    } fetch_addr_t;

endpackage

/* common/csr_pkg.sv */
package csr_pkg;

    //----------------------------------------------------------------------
    // configuration register map
    //----------------------------------------------------------------------

    typedef logic [1:0] csr_addr_t;

    localparam csr_addr_t CSR_CTRL   = 2'd0;    // enable and flush
    localparam csr_addr_t CSR_HITS   = 2'd1;    // read only
    localparam csr_addr_t CSR_MISSES = 2'd2;    // read only

    // CSR_CTRL bit positions
    localparam int CSR_CTRL_ENABLE_BIT = 0;
    localparam int CSR_CTRL_FLUSH_BIT  = 1;     // write 1 pulses flush

endpackage

/* icache/icache_arrays.sv */
`timescale 1ns/1ps
`include "icache_config.svh"

module icache_arrays import icache_pkg::*; (
    input  logic        clock,
    input  logic        reset,
    input  fetch_addr_t lookup_addr,
    input  logic        flush,
    input  logic        fill_write,
    input  line_index_t fill_index,
    input  word_sel_t   fill_word_sel,
    input  logic [31:0] fill_data,
    input  logic        fill_tag_write,
    output logic        hit,
    output logic [31:0] hit_word
);

    localparam int LINES = 1 << `ICACHE_INDEX_BITS;
    localparam int WORDS = LINES * `ICACHE_LINE_WORDS;

    tag_t        tags [LINES];
    logic [31:0] data [WORDS];
    logic [LINES-1:0] valid;

    logic fill_active;      // between first and last beat of a line
    logic flush_pending;
    logic fill_busy;

    //----------------------------------------------------------------------
    // lookup
    //----------------------------------------------------------------------

    assign hit = valid[lookup_addr.f.index] &&
                 (tags[lookup_addr.f.index] == lookup_addr.f.tag);
    assign hit_word = data[{lookup_addr.f.index, lookup_addr.f.word_sel}];

    //----------------------------------------------------------------------
    // line fill
    //----------------------------------------------------------------------

    always_ff @(posedge clock) begin
        if (fill_write)
            data[{fill_index, fill_word_sel}] <= fill_data;
        if (fill_tag_write)
            tags[fill_index] <= lookup_addr.f.tag;  // fetch address held during miss
    end

    assign fill_busy = fill_active | fill_write;

    always_ff @(posedge clock) begin
        if (reset) begin
            valid         <= '0;
            fill_active   <= 1'b0;
            flush_pending <= 1'b0;
        end else begin
            if (fill_tag_write)
                fill_active <= 1'b0;
            else if (fill_write)
                fill_active <= 1'b1;

            // flush waits until the running line fill has landed
            if ((flush | flush_pending) && !fill_busy) begin
                valid         <= '0;
                flush_pending <= 1'b0;
            end else begin
                if (flush)
                    flush_pending <= 1'b1;
                if (fill_tag_write)
                    valid[fill_index] <= 1'b1;
            end
        end
    end

endmodule

/* icache/icache_ctrl.sv */
`timescale 1ns/1ps

module icache_ctrl import icache_pkg::*; (
    input  logic        clock,
    input  logic        reset,
    input  logic        fetch_valid,
    input  fetch_addr_t fetch_addr,
    input  logic        cache_enable,
    input  logic        hit,
    input  logic [31:0] hit_word,
    input  logic        refill_done,
    input  logic [31:0] refill_word,
    output logic        fetch_ready,
    output logic [31:0] fetch_data,
    output fetch_addr_t lookup_addr,
    output logic        refill_start,
    output logic [31:0] refill_addr,
    output logic        refill_uncached,
    output logic        hit_event,
    output logic        miss_event
);

    localparam logic [1:0] S_IDLE    = 2'd0;   // also does the lookup
    localparam logic [1:0] S_WAIT    = 2'd1;   // refill or uncached read running
    localparam logic [1:0] S_RESPOND = 2'd2;
    localparam logic [1:0] S_GUARD   = 2'd3;   // skip one cycle of stale fetch_valid

    logic [1:0]  state;
    logic [31:0] data_q;
    logic        cached_hit;

    assign lookup_addr = fetch_addr;
    assign cached_hit  = cache_enable & hit;

    assign fetch_ready = (state == S_RESPOND);
    assign fetch_data  = data_q;

    //----------------------------------------------------------------------
    // fetch FSM
    //----------------------------------------------------------------------

    always_ff @(posedge clock) begin
        if (reset) begin
            state        <= S_IDLE;
            refill_start <= 1'b0;
            hit_event    <= 1'b0;
            miss_event   <= 1'b0;
        end else begin
            refill_start <= 1'b0;   // all three are single-cycle pulses
            hit_event    <= 1'b0;
            miss_event   <= 1'b0;

            case (state)
                S_IDLE: begin
                    if (fetch_valid) begin
                        if (cached_hit) begin
                            hit_event <= 1'b1;
                            state     <= S_RESPOND;
                        end else begin
                            refill_start <= 1'b1;
                            miss_event   <= cache_enable;   // no count when uncached
                            state        <= S_WAIT;
                        end
                    end
                end
                S_WAIT: begin
                    if (refill_done)
                        state <= S_RESPOND;
                end
                S_RESPOND: state <= S_GUARD;
                default:   state <= S_IDLE;
            endcase
        end
    end

    //----------------------------------------------------------------------
    // response data and refill request
    //----------------------------------------------------------------------

    always_ff @(posedge clock) begin
        if (state == S_IDLE && fetch_valid) begin
            if (cached_hit) begin
                data_q <= hit_word;
            end else begin
                refill_addr     <= fetch_addr.raw;
                refill_uncached <= ~cache_enable;
            end
        end else if (state == S_WAIT && refill_done) begin
            data_q <= refill_word;
        end
    end

endmodule

/* icache/icache_refill.sv */
`timescale 1ns/1ps
`include "icache_config.svh"

module icache_refill import icache_pkg::*; (
    input  logic        clock,
    input  logic        reset,
    input  logic        refill_start,
    input  logic [31:0] refill_addr,
    input  logic        refill_uncached,
    input  logic        mem_req_credit,
    input  logic        mem_rvalid,
    input  logic [31:0] mem_rdata,
    output logic        mem_req_valid,
    output logic [31:0] mem_req_addr,
    output logic [7:0]  mem_req_len,
    output logic        fill_write,
    output line_index_t fill_index,
    output word_sel_t   fill_word_sel,
    output logic [31:0] fill_data,
    output logic        fill_tag_write,
    output logic        refill_done,
    output logic [31:0] refill_word
);

    localparam int CREDIT_W = $clog2(`ICACHE_REQ_CREDITS + 1);
    localparam logic [CREDIT_W-1:0] CREDIT_INIT = CREDIT_W'(`ICACHE_REQ_CREDITS);
    localparam logic [7:0] LINE_LEN = 8'(`ICACHE_LINE_WORDS - 1);

    logic [CREDIT_W-1:0] credit_count;
    logic        req_pending;    // waiting for a credit
    logic        busy;           // request issued, beats outstanding
    logic        uncached_q;
    fetch_addr_t addr_q;
    fetch_addr_t req_src;
    logic        req_unc;
    word_sel_t   beat_count;
    word_sel_t   target_sel;
    logic [31:0] word_q;
    logic        issue;
    logic        beat_fire;
    logic        last_beat;
    logic        target_beat;

    //----------------------------------------------------------------------
    // request issue under credit control
    //----------------------------------------------------------------------

    assign req_src.raw = refill_start ? refill_addr : addr_q.raw;
    assign req_unc     = refill_start ? refill_uncached : uncached_q;
    assign issue       = (refill_start | req_pending) && (credit_count != '0);

    always_ff @(posedge clock) begin
        if (reset) begin
            credit_count  <= CREDIT_INIT;
            req_pending   <= 1'b0;
            mem_req_valid <= 1'b0;
        end else begin
            mem_req_valid <= issue;
            req_pending   <= (refill_start | req_pending) & ~issue;
            case ({issue, mem_req_credit})
                2'b10:   credit_count <= credit_count - 1'b1;
                2'b01:   credit_count <= credit_count + 1'b1;
                default: credit_count <= credit_count;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (refill_start) begin
            addr_q     <= refill_addr;
            uncached_q <= refill_uncached;
        end
        if (issue) begin
            if (req_unc) begin
                mem_req_addr <= {req_src.raw[31:2], 2'b00};     // exact word
                mem_req_len  <= 8'd0;
            end else begin
                mem_req_addr <= {req_src.f.tag, req_src.f.index,
                                 {`ICACHE_OFFSET_BITS{1'b0}}};  // line aligned
                mem_req_len  <= LINE_LEN;
            end
        end
    end

    //----------------------------------------------------------------------
    // beat counting
    //----------------------------------------------------------------------

    assign beat_fire   = mem_rvalid & busy;
    assign last_beat   = beat_fire & (uncached_q | (&beat_count));
    assign target_sel  = uncached_q ? '0 : addr_q.f.word_sel;
    assign target_beat = beat_fire && (beat_count == target_sel);

    always_ff @(posedge clock) begin
        if (reset) begin
            busy       <= 1'b0;
            beat_count <= '0;
        end else if (refill_start) begin
            busy       <= 1'b1;
            beat_count <= '0;
        end else if (beat_fire) begin
            beat_count <= beat_count + 1'b1;
            if (last_beat)
                busy <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (target_beat)
            word_q <= mem_rdata;
    end

    // cached beats go straight into the data array
    assign fill_write     = beat_fire & ~uncached_q;
    assign fill_index     = addr_q.f.index;
    assign fill_word_sel  = beat_count;
    assign fill_data      = mem_rdata;
    assign fill_tag_write = last_beat & ~uncached_q;

    assign refill_done = last_beat;
    assign refill_word = target_beat ? mem_rdata : word_q;  // target may be the last beat

endmodule

/* design/icache_csr.sv */
`timescale 1ns/1ps

module icache_csr import csr_pkg::*; (
    input  logic        clock,
    input  logic        reset,
    input  logic        cfg_write,
    input  csr_addr_t   cfg_addr,
    input  logic [31:0] cfg_wdata,
    input  logic        hit_event,
    input  logic        miss_event,
    output logic [31:0] cfg_rdata,
    output logic        cache_enable,
    output logic        flush
);

    logic [31:0] hit_count;
    logic [31:0] miss_count;
    logic        ctrl_write;

    assign ctrl_write = cfg_write && (cfg_addr == CSR_CTRL);

    //----------------------------------------------------------------------
    // control register
    //----------------------------------------------------------------------

    always_ff @(posedge clock) begin
        if (reset) begin
            cache_enable <= 1'b0;
            flush        <= 1'b0;
        end else begin
            flush <= ctrl_write & cfg_wdata[CSR_CTRL_FLUSH_BIT];   // one cycle only
            if (ctrl_write)
                cache_enable <= cfg_wdata[CSR_CTRL_ENABLE_BIT];
        end
    end

    //----------------------------------------------------------------------
    // performance counters
    //----------------------------------------------------------------------

    // both stick at all ones
    always_ff @(posedge clock) begin
        if (reset) begin
            hit_count  <= '0;
            miss_count <= '0;
        end else begin
            if (hit_event && hit_count != '1)
                hit_count <= hit_count + 1'b1;
            if (miss_event && miss_count != '1)
                miss_count <= miss_count + 1'b1;
        end
    end

    //----------------------------------------------------------------------
    // read decode
    //----------------------------------------------------------------------

    always_comb begin
        cfg_rdata = '0;
        case (cfg_addr)
            CSR_CTRL:   cfg_rdata[CSR_CTRL_ENABLE_BIT] = cache_enable;  // flush reads 0
            CSR_HITS:   cfg_rdata = hit_count;
            CSR_MISSES: cfg_rdata = miss_count;
            default:    cfg_rdata = '0;
        endcase
    end

endmodule

/* design/icache_top.sv */
`timescale 1ns/1ps

module icache_top import icache_pkg::*, csr_pkg::*; (
    input  logic        clock,
    input  logic        reset,

    // fetch port
    input  logic        fetch_valid,
    input  logic [31:0] fetch_addr,
    output logic        fetch_ready,
    output logic [31:0] fetch_data,

    // memory request channel
    output logic        mem_req_valid,
    output logic [31:0] mem_req_addr,
    output logic [7:0]  mem_req_len,
    input  logic        mem_req_credit,

    // memory return
    input  logic        mem_rvalid,
    input  logic [31:0] mem_rdata,

    // configuration port
    input  logic        cfg_write,
    input  csr_addr_t   cfg_addr,
    input  logic [31:0] cfg_wdata,
    output logic [31:0] cfg_rdata
);

    logic        cache_enable;
    logic        flush;
    logic        hit_event;
    logic        miss_event;

    fetch_addr_t lookup_addr;
    logic        hit;
    logic [31:0] hit_word;

    // controller to refill
    logic        refill_start;
    logic [31:0] refill_addr;
    logic        refill_uncached;
    logic        refill_done;
    logic [31:0] refill_word;

    // refill to arrays
    logic        fill_write;
    line_index_t fill_index;
    word_sel_t   fill_word_sel;
    logic [31:0] fill_data;
    logic        fill_tag_write;

    icache_csr icache_csr_i (
        .clock, .reset,
        .cfg_write, .cfg_addr, .cfg_wdata,
        .hit_event, .miss_event,
        .cfg_rdata, .cache_enable, .flush
    );

    icache_ctrl icache_ctrl_i (
        .clock, .reset,
        .fetch_valid, .fetch_addr,
        .cache_enable, .hit, .hit_word,
        .refill_done, .refill_word,
        .fetch_ready, .fetch_data, .lookup_addr,
        .refill_start, .refill_addr, .refill_uncached,
        .hit_event, .miss_event
    );

    icache_arrays icache_arrays_i (
        .clock, .reset,
        .lookup_addr, .flush,
        .fill_write, .fill_index, .fill_word_sel, .fill_data, .fill_tag_write,
        .hit, .hit_word
    );

    icache_refill icache_refill_i (
        .clock, .reset,
        .refill_start, .refill_addr, .refill_uncached,
        .mem_req_credit, .mem_rvalid, .mem_rdata,
        .mem_req_valid, .mem_req_addr, .mem_req_len,
        .fill_write, .fill_index, .fill_word_sel, .fill_data, .fill_tag_write,
        .refill_done, .refill_word
    );

endmodule

/* test/icache_mem_model.sv */
`timescale 1ns/1ps
`include "icache_config.svh"

module icache_mem_model (
    input  logic        clock,
    input  logic        reset,
    input  logic        mem_req_valid,
    input  logic [31:0] mem_req_addr,
    input  logic [7:0]  mem_req_len,
    output logic        mem_req_credit,
    output logic        mem_rvalid,
    output logic [31:0] mem_rdata,
    output logic        credit_error    // sticky, request seen with no credit out
);

    logic [31:0] req_addr_q [$];
    logic [7:0]  req_len_q [$];
    logic [31:0] rand_state;
    logic [31:0] beat_addr;
    logic        credit_due;
    int          credits;       // credits the cache holds right now
    int          beats_left;
    int          delay;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // rotate left by 7, then scramble
    function automatic logic [31:0] stored_word(input logic [31:0] a);
        return {a[24:0], a[31:25]} ^ 32'h5a5a0f0f;
    endfunction

    initial begin
        mem_req_credit = 1'b0;
        mem_rvalid     = 1'b0;
        mem_rdata      = '0;
        credit_error   = 1'b0;
        credit_due     = 1'b0;
        rand_state     = 32'h96ba;
        beat_addr      = '0;
        credits        = `ICACHE_REQ_CREDITS;
        beats_left     = 0;
        delay          = 0;
        forever begin
            @(posedge clock);
            #0.5;
            mem_rvalid     = 1'b0;
            mem_req_credit = 1'b0;
            if (reset) begin
                credits    = `ICACHE_REQ_CREDITS;
                beats_left = 0;
                credit_due = 1'b0;
                req_addr_q.delete();
                req_len_q.delete();
            end else begin
                if (credit_due) begin
                    mem_req_credit = 1'b1;
                    credits        = credits + 1;
                    credit_due     = 1'b0;
                end
                if (mem_req_valid) begin
                    if (credits == 0)
                        credit_error = 1'b1;
                    else
                        credits = credits - 1;
                    req_addr_q.push_back(mem_req_addr);
                    req_len_q.push_back(mem_req_len);
                end
                if (beats_left > 0) begin
                    if (delay > 0) begin
                        delay = delay - 1;
                    end else begin
                        mem_rvalid = 1'b1;
                        mem_rdata  = stored_word(beat_addr);
                        beat_addr  = beat_addr + 32'd4;
                        beats_left = beats_left - 1;
                        rand_state = lcg_next(rand_state);
                        delay      = int'(rand_state[17:16]);   // 0 to 3 idle cycles
                        if (beats_left == 0)
                            credit_due = 1'b1;
                    end
                end else if (req_addr_q.size() > 0) begin
                    beat_addr  = req_addr_q.pop_front();
                    beats_left = int'(req_len_q.pop_front()) + 1;
                    rand_state = lcg_next(rand_state);
                    delay      = int'(rand_state[17:16]);
                end
            end
        end
    end

endmodule

/* test/icache_tb.sv */
`timescale 1ns/1ps
`include "icache_config.svh"

module icache_tb import csr_pkg::*; ();

    localparam int CLOCK_PERIOD    = 4;
    localparam int NUM_RANDOM      = 200;
    localparam int NUM_UNCACHED    = 8;
    localparam int NUM_FETCHES     = NUM_RANDOM + NUM_UNCACHED + 2;
    localparam int WATCHDOG_CYCLES = NUM_FETCHES * 200 + 300;  // slack for reset and CSR access
    localparam int LINES           = 1 << `ICACHE_INDEX_BITS;
    localparam int LINE_BEATS      = (1 << `ICACHE_OFFSET_BITS) / 4;
    localparam logic [31:0] LINE_MASK   = ~((32'd1 << `ICACHE_OFFSET_BITS) - 32'd1);
    localparam logic [31:0] WINDOW_BASE = 32'h0000_2000;

    logic        clock = 1'b0;
    logic        reset;
    logic        fetch_valid;
    logic [31:0] fetch_addr;
    logic        fetch_ready;
    logic [31:0] fetch_data;
    logic        mem_req_valid;
    logic [31:0] mem_req_addr;
    logic [7:0]  mem_req_len;
    logic        mem_req_credit;
    logic        mem_rvalid;
    logic [31:0] mem_rdata;
    logic        cfg_write;
    csr_addr_t   cfg_addr;
    logic [31:0] cfg_wdata;
    logic [31:0] cfg_rdata;
    logic        credit_error;

    logic [31:0] rand_state;
    logic [31:0] expect_q [$];      // fetch addresses still waiting for data
    int          req_count = 0;
    logic [31:0] last_req_addr;
    logic [7:0]  last_req_len;

    // reference tag model
    logic [LINES-1:0] ref_valid;
    logic [31:0]      ref_tag [LINES];
    logic             ref_enable;
    int               exp_hits;
    int               exp_misses;

    icache_top icache_top_i (.*);

    icache_mem_model icache_mem_model_i (.*);

    always #(CLOCK_PERIOD / 2) clock = ~clock;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] mem_word(input logic [31:0] a);
        return {a[24:0], a[31:25]} ^ 32'h5a5a0f0f;
    endfunction

    function automatic logic predict_hit(input logic [31:0] a);
        logic [31:0] line;
        line = a >> `ICACHE_OFFSET_BITS;
        return ref_enable && ref_valid[line[`ICACHE_INDEX_BITS-1:0]] &&
               (ref_tag[line[`ICACHE_INDEX_BITS-1:0]] == (line >> `ICACHE_INDEX_BITS));
    endfunction

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("TB FAILED");
        $fatal(1, "testbench stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        if (got !== want)
            stop_with_failure($sformatf("mismatch at %0t ns: %s got %h, expected %h",
                                        $time, name, got, want));
    endtask

    task automatic step_cycle();
        @(posedge clock);
        #0.5;
    endtask

    task automatic csr_write(input csr_addr_t a, input logic [31:0] d);
        cfg_write = 1'b1;
        cfg_addr  = a;
        cfg_wdata = d;
        step_cycle();
        cfg_write = 1'b0;
        step_cycle();   // flush lands one cycle after the write
    endtask

    task automatic csr_read(input csr_addr_t a, output logic [31:0] d);
        cfg_addr = a;
        @(negedge clock);
        d = cfg_rdata;
        step_cycle();
    endtask

    task automatic check_counters();
        logic [31:0] value;
        csr_read(CSR_HITS, value);
        check_value("cfg_rdata (CSR_HITS)", value, 32'(exp_hits));
        csr_read(CSR_MISSES, value);
        check_value("cfg_rdata (CSR_MISSES)", value, 32'(exp_misses));
    endtask

    task automatic fetch_and_check(input logic [31:0] addr);
        logic        will_hit;
        logic [31:0] line;
        int          reqs_before;
        int          cycles;
        will_hit    = predict_hit(addr);
        line        = addr >> `ICACHE_OFFSET_BITS;
        reqs_before = req_count;
        cycles      = 0;
        expect_q.push_back(addr);
        fetch_valid = 1'b1;
        fetch_addr  = addr;
        do begin
            step_cycle();
            cycles = cycles + 1;
        end while (!fetch_ready);
        fetch_valid = 1'b0;
        repeat (2) step_cycle();    // respond and guard states
        if (will_hit) begin
            check_value("fetch_ready latency", 32'(cycles), 32'd1);
            check_value("mem_req_valid count", 32'(req_count - reqs_before), 32'd0);
            exp_hits = exp_hits + 1;
        end else begin
            check_value("mem_req_valid count", 32'(req_count - reqs_before), 32'd1);
            if (ref_enable) begin
                check_value("mem_req_addr", last_req_addr, addr & LINE_MASK);
                check_value("mem_req_len", 32'(last_req_len), 32'(LINE_BEATS - 1));
                exp_misses = exp_misses + 1;
                ref_valid[line[`ICACHE_INDEX_BITS-1:0]] = 1'b1;
                ref_tag[line[`ICACHE_INDEX_BITS-1:0]]   = line >> `ICACHE_INDEX_BITS;
            end else begin
                check_value("mem_req_addr", last_req_addr, addr);
                check_value("mem_req_len", 32'(last_req_len), 32'd0);
            end
        end
    endtask

    //----------------------------------------------------------------------
    // compare process, samples at the falling edge
    //----------------------------------------------------------------------

    always @(negedge clock) begin
        if (!reset) begin
            if (credit_error)
                stop_with_failure("memory model got a request while the cache held no credit");
            if (mem_req_valid) begin
                req_count     = req_count + 1;
                last_req_addr = mem_req_addr;
                last_req_len  = mem_req_len;
            end
            if (fetch_ready) begin
                if (expect_q.size() == 0)
                    stop_with_failure("fetch_ready rose with no fetch outstanding");
                else
                    check_value("fetch_data", fetch_data, mem_word(expect_q.pop_front()));
            end
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLOCK_PERIOD);
        stop_with_failure("watchdog expired before the test sequence finished");
    end

    //----------------------------------------------------------------------
    // stimulus
    //----------------------------------------------------------------------

    initial begin
        logic [31:0] addr;
        logic [31:0] repeat_addr;
        logic [31:0] value;
        reset       = 1'b1;
        fetch_valid = 1'b0;
        fetch_addr  = '0;
        cfg_write   = 1'b0;
        cfg_addr    = CSR_CTRL;
        cfg_wdata   = '0;
        rand_state  = 32'h96ba;
        ref_valid   = '0;
        ref_enable  = 1'b0;
        exp_hits    = 0;
        exp_misses  = 0;
        addr        = WINDOW_BASE;
        repeat (10) @(posedge clock);
        #0.5;
        reset = 1'b0;
        check_counters();

        csr_write(CSR_CTRL, 32'h1);
        ref_enable = 1'b1;
        for (int i = 0; i < NUM_RANDOM; i++) begin
            rand_state = lcg_next(rand_state);
            addr = WINDOW_BASE + {23'd0, rand_state[24:18], 2'b00};     // 512-byte window
            fetch_and_check(addr);
        end
        check_counters();

        // same address again right away, must hit
        repeat_addr = addr;
        fetch_and_check(repeat_addr);

        csr_write(CSR_CTRL, 32'h3);     // keep enable, pulse flush
        ref_valid = '0;
        csr_read(CSR_CTRL, value);
        check_value("cfg_rdata (CSR_CTRL)", value, 32'd1);
        fetch_and_check(repeat_addr);
        check_counters();

        // uncached reads leave counters alone
        csr_write(CSR_CTRL, 32'h0);
        ref_enable = 1'b0;
        fetch_and_check(repeat_addr);
        for (int i = 1; i < NUM_UNCACHED; i++) begin
            rand_state = lcg_next(rand_state);
            fetch_and_check(WINDOW_BASE + {23'd0, rand_state[24:18], 2'b00});
        end
        check_counters();

        $display("TB PASSED");
        $finish;
    end

endmodule

/* files.f */
+incdir+common
common/icache_pkg.sv
common/csr_pkg.sv
icache/icache_arrays.sv
icache/icache_ctrl.sv
icache/icache_refill.sv
design/icache_csr.sv
design/icache_top.sv
test/icache_mem_model.sv
test/icache_tb.sv

/* run.sh */
#!/bin/sh
# build and run the icache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps \
    --top-module icache_tb -f files.f -o icache_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/icache_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit "$status"
fi

exit 0
